// ==== bertBoardTop.f ====
rtl/bertPkg.sv
rtl/regBusDecode.sv
rtl/boardRegs.sv
rtl/serialInputSync.sv
rtl/clockDataMux.sv
rtl/pnGenerator.sv
rtl/bertCore.sv
rtl/bertBoardTop.sv
dv/bertCore_assertions.sv
dv/bertBoardTb.sv

// ==== dv/bertBoardTb.sv ====
`timescale 1ns/100ps

module bertBoardTb;
    import bertPkg::*;

    localparam logic [BusDataWidth-1:0] TbVersion = 16'h0213;
    localparam int SerialBits = 200;
    localparam int NumFlips   = 4;
    // Serial test takes 8 cycles per bit and the other tests well under 2000 cycles in total
    localparam int TimeoutCycles = 20000;

    logic                    clk;
    logic                    reset;
    regBus_t                 bus;
    logic [BusDataWidth-1:0] readData;
    logic                    serialClkIn;
    logic                    serialDataIn;
    logic                    serialClkOut;
    logic                    serialDataOut;
    logic                    lockn;
    logic [31:0]             lcgState;
    int                      cycleCount = 0;
    int                      errors = 0;
    int                      testErrors = 0;
    int                      testsRun = 0;
    int                      testsFailed = 0;

    bertBoardTop #(.VersionNumber(TbVersion)) i_dut (
        .clk(clk), .reset(reset), .bus(bus), .readData(readData),
        .serialClkIn(serialClkIn), .serialDataIn(serialDataIn),
        .serialClkOut(serialClkOut), .serialDataOut(serialDataOut), .lockn(lockn)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= TimeoutCycles) begin
            $display("Timeout: run stopped after %0d cycles", cycleCount);
            $display("Result: FAILED");
            $finish;
        end
    end

//****************************************************************************
//                          Reference models and helpers
//****************************************************************************
    // PN15 step for x^15 + x^14 + 1
    function automatic logic [14:0] pnNext(input logic [14:0] state);
        return {state[13:0], state[14] ^ state[13]};
    endfunction

    function automatic logic [31:0] lcgNext();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    task automatic noteFail(input string msg);
        $display("Fail at %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic finishTest(input string name);
        testsRun++;
        if (errors == testErrors) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, errors - testErrors);
            testsFailed++;
        end
        testErrors = errors;
    endtask

    // Bus tasks start and end on a falling edge
    task automatic writeReg(input logic [7:0] addr, input logic [15:0] data);
        bus.addr      = addr;
        bus.write     = 1'b1;
        bus.writeData = data;
        @(negedge clk);
        bus = '0;
    endtask

    task automatic readReg(input logic [7:0] addr, output logic [15:0] data);
        bus.addr = addr;
        bus.read = 1'b1;
        @(negedge clk);
        bus  = '0;
        data = readData;
    endtask

    task automatic writeReadBack(input logic [7:0] addr, input logic [15:0] data);
        logic [15:0] value;
        writeReg(addr, data);
        readReg(addr, value);
        if (value !== data) begin
            noteFail($sformatf("address %h read %h, wrote %h", addr, value, data));
        end
    endtask

    task automatic sendSerialBit(input logic bitValue);
        serialDataIn = bitValue;
        serialClkIn  = 1'b0;
        repeat (4) @(negedge clk);
        serialClkIn = 1'b1;
        repeat (4) @(negedge clk);
    endtask

//****************************************************************************
//                          Directed tests
//****************************************************************************
    task automatic resetValues();
        logic [15:0] value;
        readReg({SpaceBoard, RegVersion}, value);
        if (value !== TbVersion) begin
            noteFail($sformatf("version %h, expected %h", value, TbVersion));
        end
        if (lockn !== 1'b1) begin
            noteFail("lockn low after reset");
        end
        readReg({SpaceBert, RegBitCount}, value);
        if (value !== 16'h0) begin
            noteFail($sformatf("bit count %h after reset", value));
        end
        readReg({SpaceBert, RegErrorCount}, value);
        if (value !== 16'h0) begin
            noteFail($sformatf("error count %h after reset", value));
        end
        writeReadBack({SpaceBoard, RegControl}, 16'h0002);
        writeReadBack({SpaceBoard, RegBertSelect}, 16'h0005);
        writeReadBack({SpaceBoard, RegOutSelect}, 16'h000a);
        writeReadBack({SpacePn, RegPnRate}, 16'h1234);
        readReg(8'h37, value);
        if (value !== 16'h0) begin
            noteFail($sformatf("unmapped address read %h", value));
        end
        writeReg({SpaceBoard, RegControl}, 16'h0000);
        writeReg({SpaceBoard, RegBertSelect}, 16'(SrcPn));
        writeReg({SpaceBoard, RegOutSelect}, 16'(SrcPn));
        finishTest("reset and registers");
    endtask

    task automatic pnOutput();
        logic [59:0] bits;
        int          stamps [60];
        int          n = 0;
        int          cycle = 0;
        logic [14:0] pnState;
        writeReg({SpacePn, RegPnRate}, 16'd3);
        writeReg({SpaceBoard, RegControl}, 16'h0001);
        while (n < 60) begin
            @(negedge clk);
            cycle++;
            if (serialClkOut) begin
                bits[n]   = serialDataOut;
                stamps[n] = cycle;
                n++;
            end
        end
        // Generator has not stepped since reset so the reference starts at the seed
        pnState = PnSeed;
        for (int i = 0; i < 60; i++) begin
            if (bits[i] !== pnState[14]) begin
                noteFail($sformatf("PN bit %0d is %b, expected %b", i, bits[i], pnState[14]));
            end
            pnState = pnNext(pnState);
            if (i > 0 && stamps[i] - stamps[i-1] != 4) begin
                noteFail($sformatf("strobe interval %0d cycles", stamps[i] - stamps[i-1]));
            end
        end
        finishTest("PN output");
    endtask

    task automatic loopback();
        logic [15:0] first;
        logic [15:0] second;
        logic [15:0] errs;
        writeReg({SpaceBert, RegBitCount}, 16'h0);
        writeReg({SpaceBoard, RegControl}, 16'h0003);
        while (lockn) begin
            @(negedge clk);
        end
        repeat (200) @(negedge clk);
        readReg({SpaceBert, RegBitCount}, first);
        repeat (100) @(negedge clk);
        readReg({SpaceBert, RegBitCount}, second);
        readReg({SpaceBert, RegErrorCount}, errs);
        if (first == 16'h0 || second <= first) begin
            noteFail($sformatf("bit count did not rise, %0d then %0d", first, second));
        end
        if (errs !== 16'h0) begin
            noteFail($sformatf("loopback error count %0d", errs));
        end
        finishTest("PN loopback");
    endtask

    task automatic serialErrors();
        logic [SerialBits-1:0] flip;
        logic [14:0]           pnState;
        logic [15:0]           value;
        int                    pos;
        flip = '0;
        // One flip per 40-bit slot past the fill and clear of the last taps
        for (int f = 0; f < NumFlips; f++) begin
            pos       = 16 + 40 * f + int'((lcgNext() >> 16) % 20);
            flip[pos] = 1'b1;
        end
        writeReg({SpaceBoard, RegBertSelect}, 16'(SrcSerialIn));
        writeReg({SpaceBert, RegBitCount}, 16'h0);
        if (lockn !== 1'b1) begin
            noteFail("lockn low after counter clear");
        end
        pnState = PnSeed;
        for (int i = 0; i < SerialBits; i++) begin
            sendSerialBit(pnState[14] ^ flip[i]);
            pnState = pnNext(pnState);
        end
        // Pin to counter takes 5 cycles
        repeat (8) @(negedge clk);
        readReg({SpaceBert, RegBitCount}, value);
        if (value !== 16'(SerialBits - 15)) begin
            noteFail($sformatf("bit count %0d, expected %0d", value, SerialBits - 15));
        end
        readReg({SpaceBert, RegErrorCount}, value);
        if (value !== 16'(3 * NumFlips)) begin
            noteFail($sformatf("error count %0d, expected %0d", value, 3 * NumFlips));
        end
        finishTest("serial input with errors");
    endtask

    task automatic disabledHold();
        logic [15:0] bitsBefore;
        logic [15:0] errsBefore;
        logic [15:0] value;
        writeReg({SpaceBoard, RegControl}, 16'h0001);
        writeReg({SpaceBoard, RegBertSelect}, 16'(SrcPn));
        readReg({SpaceBert, RegBitCount}, bitsBefore);
        readReg({SpaceBert, RegErrorCount}, errsBefore);
        repeat (100) @(negedge clk);
        readReg({SpaceBert, RegBitCount}, value);
        if (value !== bitsBefore) begin
            noteFail($sformatf("bit count moved from %0d to %0d", bitsBefore, value));
        end
        readReg({SpaceBert, RegErrorCount}, value);
        if (value !== errsBefore) begin
            noteFail($sformatf("error count moved from %0d to %0d", errsBefore, value));
        end
        writeReg({SpaceBert, RegBitCount}, 16'h0);
        readReg({SpaceBert, RegBitCount}, value);
        if (value !== 16'h0) begin
            noteFail($sformatf("bit count %0d after clear", value));
        end
        readReg({SpaceBert, RegErrorCount}, value);
        if (value !== 16'h0) begin
            noteFail($sformatf("error count %0d after clear", value));
        end
        if (lockn !== 1'b1) begin
            noteFail("lockn low after clear");
        end
        finishTest("disabled BERT and clear");
    endtask

    task automatic idleOutput();
        writeReg({SpaceBoard, RegOutSelect}, 16'h000d);
        repeat (3) @(negedge clk);
        for (int i = 0; i < 20; i++) begin
            if (serialClkOut !== 1'b1 || serialDataOut !== 1'b0) begin
                noteFail($sformatf("idle pins clk %b data %b", serialClkOut, serialDataOut));
            end
            @(negedge clk);
        end
        finishTest("idle output inverted");
    endtask

    initial begin
        lcgState     = 32'h7c84d244;
        reset        = 1'b1;
        bus          = '0;
        serialClkIn  = 1'b0;
        serialDataIn = 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        resetValues();
        pnOutput();
        loopback();
        serialErrors();
        disabledHold();
        idleOutput();
        $display("Tests run: %0d, failed: %0d, errors: %0d", testsRun, testsFailed, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== dv/bertCore_assertions.sv ====
`timescale 1ns/100ps

module bertCore_assertions (
    input logic                             clk,
    input logic                             reset,
    input logic                             bertEnable,
    input bertPkg::regBus_t                 bus,
    input logic                             bertSel,
    input bertPkg::bitStream_t              bertStream,
    input logic                             lockn,
    input logic [bertPkg::BusDataWidth-1:0] bitCount,
    input logic [bertPkg::BusDataWidth-1:0] errorCount
);
    import bertPkg::*;

    logic clear;
    logic accepted;
    int   strobesSinceClear;

    assign clear = bertSel && bus.write &&
                   (bus.addr[3:0] == RegBitCount || bus.addr[3:0] == RegErrorCount);
    assign accepted = bertEnable && bertStream.clkEn;

    // Saturates once the history is full
    always_ff @(posedge clk) begin
        if (reset || clear) begin
            strobesSinceClear <= 0;
        end else if (accepted && strobesSinceClear < PnLength) begin
            strobesSinceClear <= strobesSinceClear + 1;
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        strobesSinceClear < PnLength |-> lockn)
        else $error("lockn low after only %0d strobes", strobesSinceClear);

    assert property (@(posedge clk) disable iff (reset)
        !bertStream.clkEn |=> errorCount != $past(errorCount) + 1'b1)
        else $error("error count rose without a strobe");

    assert property (@(posedge clk) disable iff (reset)
        !bertEnable && !clear |=> $stable(bitCount) && $stable(errorCount))
        else $error("counters changed while the BERT was disabled");

endmodule

bind bertCore bertCore_assertions bertChecks (
    .clk(clk), .reset(reset), .bertEnable(bertEnable), .bus(bus), .bertSel(bertSel),
    .bertStream(bertStream), .lockn(lockn), .bitCount(bitCount), .errorCount(errorCount)
);

// ==== rtl/bertBoardTop.sv ====
`timescale 1ns/100ps

module bertBoardTop #(
    parameter logic [bertPkg::BusDataWidth-1:0] VersionNumber = 16'h0100
) (
    input  logic                             clk,
    input  logic                             reset,
    input  bertPkg::regBus_t                 bus,
    output logic [bertPkg::BusDataWidth-1:0] readData,
    input  logic                             serialClkIn,
    input  logic                             serialDataIn,
    output logic                             serialClkOut,
    output logic                             serialDataOut,
    output logic                             lockn
);
    import bertPkg::*;

    localparam bitStream_t IdleStream = '0;

    logic                    boardSel;
    logic                    pnSel;
    logic                    bertSel;
    logic [BusDataWidth-1:0] boardRead;
    logic [BusDataWidth-1:0] pnRead;
    logic [BusDataWidth-1:0] bertRead;
    logic                    pnEnable;
    logic                    bertEnable;
    logic [2:0]              bertSelect;
    logic [2:0]              outSelect;
    logic                    outClkInvert;
    bitStream_t              pnStream;
    bitStream_t              serialStream;
    bitStream_t              bertStream;
    bitStream_t              outStream;
    wire bitStream_t [NumStreams-1:0] sources;

//**************************************************************************
//                          Register bus
//**************************************************************************
    regBusDecode busDecode (
        .clk(clk), .reset(reset), .bus(bus),
        .boardSel(boardSel), .pnSel(pnSel), .bertSel(bertSel),
        .boardRead(boardRead), .pnRead(pnRead), .bertRead(bertRead),
        .readData(readData)
    );

    boardRegs #(.VersionNumber(VersionNumber)) topRegs (
        .clk(clk), .reset(reset), .bus(bus), .boardSel(boardSel),
        .boardRead(boardRead),
        .pnEnable(pnEnable), .bertEnable(bertEnable),
        .bertSelect(bertSelect), .outSelect(outSelect),
        .outClkInvert(outClkInvert)
    );

//**************************************************************************
//                          Pattern sources
//**************************************************************************
    serialInputSync inSync (
        .clk(clk), .reset(reset),
        .serialClkIn(serialClkIn), .serialDataIn(serialDataIn),
        .serialStream(serialStream)
    );

    pnGenerator pnGen (
        .clk(clk), .reset(reset), .pnEnable(pnEnable),
        .bus(bus), .pnSel(pnSel), .pnRead(pnRead),
        .pnStream(pnStream)
    );

    assign sources[SrcPn]       = pnStream;
    assign sources[SrcSerialIn] = serialStream;

    // Remaining mux inputs stay idle
    for (genvar i = SrcSerialIn + 1; i < NumStreams; i++) begin : gIdle
        assign sources[i] = IdleStream;
    end

//**************************************************************************
//                          BERT and output pins
//**************************************************************************
    clockDataMux #(.NumStreams(NumStreams)) bertMux (
        .clk(clk), .reset(reset),
        .streams(sources), .select(bertSelect), .outStream(bertStream)
    );

    bertCore bert (
        .clk(clk), .reset(reset), .bertEnable(bertEnable),
        .bus(bus), .bertSel(bertSel), .bertRead(bertRead),
        .bertStream(bertStream), .lockn(lockn)
    );

    clockDataMux #(.NumStreams(NumStreams)) outMux (
        .clk(clk), .reset(reset),
        .streams(sources), .select(outSelect), .outStream(outStream)
    );

    assign serialClkOut  = outStream.clkEn ^ outClkInvert;
    assign serialDataOut = outStream.data;

endmodule

// ==== rtl/bertCore.sv ====
`timescale 1ns/100ps

module bertCore (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             bertEnable,
    input  bertPkg::regBus_t                 bus,
    input  logic                             bertSel,
    output logic [bertPkg::BusDataWidth-1:0] bertRead,
    input  bertPkg::bitStream_t              bertStream,
    output logic                             lockn
);
    import bertPkg::*;

    logic [PnLength-1:0]            history;
    logic [$clog2(PnLength+1)-1:0]  fillCount;
    logic [BusDataWidth-1:0]        bitCount;
    logic [BusDataWidth-1:0]        errorCount;
    logic                           locked;
    logic                           predicted;
    logic                           bitStrobe;
    logic                           counterClear;

//**************************************************************************
//                          Register access
//**************************************************************************
    // Writing either counter restarts the measurement
    assign counterClear = bertSel && bus.write &&
                          (bus.addr[3:0] == RegBitCount || bus.addr[3:0] == RegErrorCount);

    always_comb begin
        case (bus.addr[3:0])
            RegBitCount:   bertRead = bitCount;
            RegErrorCount: bertRead = errorCount;
            default:       bertRead = '0;
        endcase
    end

//**************************************************************************
//                          PN15 checker
//**************************************************************************
    assign bitStrobe = bertEnable & bertStream.clkEn;
    assign locked    = (fillCount == PnLength);
    assign lockn     = ~locked;

    // Same feedback rule as the generator
    assign predicted = history[PnLength-1] ^ history[PnLength-2];

    // History follows the received bits, errors included
    always_ff @(posedge clk) begin
        if (bitStrobe) begin
            history <= {history[PnLength-2:0], bertStream.data};
        end
    end

    always_ff @(posedge clk) begin
        if (reset || counterClear) begin
            fillCount  <= '0;
            bitCount   <= '0;
            errorCount <= '0;
        end else if (bitStrobe) begin
            if (!locked) begin
                fillCount <= fillCount + 1'b1;
            end else begin
                bitCount <= bitCount + 1'b1;
                if (bertStream.data != predicted) begin
                    errorCount <= errorCount + 1'b1;
                end
            end
        end
    end

endmodule

// ==== rtl/pnGenerator.sv ====
`timescale 1ns/100ps

module pnGenerator (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             pnEnable,
    input  bertPkg::regBus_t                 bus,
    input  logic                             pnSel,
    output logic [bertPkg::BusDataWidth-1:0] pnRead,
    output bertPkg::bitStream_t              pnStream
);
    import bertPkg::*;

    logic [BusDataWidth-1:0] pnRate;
    logic [BusDataWidth-1:0] rateCount;
    logic [PnLength-1:0]     pnReg;
    logic                    bitTick;

    always_ff @(posedge clk) begin
        if (reset) begin
            pnRate <= '0;
        end else if (pnSel && bus.write && bus.addr[3:0] == RegPnRate) begin
            pnRate <= bus.writeData;
        end
    end

    always_comb begin
        case (bus.addr[3:0])
            RegPnRate: pnRead = pnRate;
            default:   pnRead = '0;
        endcase
    end

    // One bit every pnRate+1 cycles
    assign bitTick = pnEnable && (rateCount == pnRate);

    always_ff @(posedge clk) begin
        if (reset) begin
            rateCount <= '0;
            pnReg     <= PnSeed;
            pnStream  <= '0;
        end else begin
            pnStream.clkEn <= bitTick;
            if (!pnEnable || bitTick) begin
                rateCount <= '0;
            end else begin
                rateCount <= rateCount + 1'b1;
            end
            if (bitTick) begin
                // Send the MSB, feed back bit 14 xor bit 13
                pnStream.data <= pnReg[PnLength-1];
                pnReg <= {pnReg[PnLength-2:0], pnReg[PnLength-1] ^ pnReg[PnLength-2]};
            end
        end
    end

endmodule

// ==== rtl/clockDataMux.sv ====
`timescale 1ns/100ps

module clockDataMux #(
    parameter int NumStreams = bertPkg::NumStreams
) (
    input  logic                                 clk,
    input  logic                                 reset,
    input  bertPkg::bitStream_t [NumStreams-1:0] streams,
    input  logic [$clog2(NumStreams)-1:0]        select,
    output bertPkg::bitStream_t                  outStream
);
    // Registered so every output sees one aligned strobe
    always_ff @(posedge clk) begin
        if (reset) begin
            outStream <= '0;
        end else begin
            outStream <= streams[select];
        end
    end

endmodule

// ==== rtl/serialInputSync.sv ====
`timescale 1ns/100ps

module serialInputSync (
    input  logic                clk,
    input  logic                reset,
    input  logic                serialClkIn,
    input  logic                serialDataIn,
    output bertPkg::bitStream_t serialStream
);
    logic [1:0] clkSync;
    logic [1:0] dataSync;
    logic       clkDelay;
    logic       risingEdge;

    // Two flops on each pin, data kept in step with the clock
    always_ff @(posedge clk) begin
        if (reset) begin
            clkSync  <= '0;
            clkDelay <= 1'b0;
        end else begin
            clkSync  <= {clkSync[0], serialClkIn};
            clkDelay <= clkSync[1];
        end
    end

    always_ff @(posedge clk) begin
        dataSync <= {dataSync[0], serialDataIn};
    end

    assign risingEdge = clkSync[1] & ~clkDelay;

    // One strobe per rising edge of the external clock
    always_ff @(posedge clk) begin
        if (risingEdge) begin
            serialStream.data <= dataSync[1];
        end
        if (reset) begin
            serialStream.clkEn <= 1'b0;
        end else begin
            serialStream.clkEn <= risingEdge;
        end
    end

endmodule

// ==== rtl/boardRegs.sv ====
`timescale 1ns/100ps

module boardRegs #(
    parameter logic [bertPkg::BusDataWidth-1:0] VersionNumber = 16'h0100
) (
    input  logic                             clk,
    input  logic                             reset,
    input  bertPkg::regBus_t                 bus,
    input  logic                             boardSel,
    output logic [bertPkg::BusDataWidth-1:0] boardRead,
    output logic                             pnEnable,
    output logic                             bertEnable,
    output logic [2:0]                       bertSelect,
    output logic [2:0]                       outSelect,
    output logic                             outClkInvert
);
    import bertPkg::*;

    logic       regWrite;
    logic [3:0] offset;

    assign offset   = bus.addr[3:0];
    assign regWrite = boardSel & bus.write;

    always_ff @(posedge clk) begin
        if (reset) begin
            pnEnable     <= 1'b0;
            bertEnable   <= 1'b0;
            bertSelect   <= '0;
            outSelect    <= '0;
            outClkInvert <= 1'b0;
        end else if (regWrite) begin
            case (offset)
                RegControl: begin
                    pnEnable   <= bus.writeData[0];
                    bertEnable <= bus.writeData[1];
                end
                RegBertSelect: bertSelect <= bus.writeData[2:0];
                RegOutSelect: begin
                    outSelect    <= bus.writeData[2:0];
                    outClkInvert <= bus.writeData[3];
                end
                default: ;
            endcase
        end
    end

    // Read back by offset
    always_comb begin
        boardRead = '0;
        case (offset)
            RegVersion:    boardRead = VersionNumber;
            RegControl:    boardRead[1:0] = {bertEnable, pnEnable};
            RegBertSelect: boardRead[2:0] = bertSelect;
            RegOutSelect:  boardRead[3:0] = {outClkInvert, outSelect};
            default:       boardRead = '0;
        endcase
    end

endmodule

// ==== rtl/regBusDecode.sv ====
`timescale 1ns/100ps

module regBusDecode (
    input  logic                             clk,
    input  logic                             reset,
    input  bertPkg::regBus_t                 bus,
    output logic                             boardSel,
    output logic                             pnSel,
    output logic                             bertSel,
    input  logic [bertPkg::BusDataWidth-1:0] boardRead,
    input  logic [bertPkg::BusDataWidth-1:0] pnRead,
    input  logic [bertPkg::BusDataWidth-1:0] bertRead,
    output logic [bertPkg::BusDataWidth-1:0] readData
);
    import bertPkg::*;

    logic [3:0]              space;
    logic [BusDataWidth-1:0] readMux;

    assign space    = bus.addr[7:4];
    assign boardSel = (space == SpaceBoard);
    assign pnSel    = (space == SpacePn);
    assign bertSel  = (space == SpaceBert);

    // Read word of the owning block, zero outside the map
    always_comb begin
        case (space)
            SpaceBoard: readMux = boardRead;
            SpacePn:    readMux = pnRead;
            SpaceBert:  readMux = bertRead;
            default:    readMux = '0;
        endcase
    end

    // Held until the next read strobe
    always_ff @(posedge clk) begin
        if (reset) begin
            readData <= '0;
        end else if (bus.read) begin
            readData <= readMux;
        end
    end

endmodule

// ==== rtl/bertPkg.sv ====
package bertPkg;

    // Register bus
    localparam int BusDataWidth = 16;

    typedef struct packed {
        logic [7:0]              addr;
        logic                    write;
        logic                    read;
        logic [BusDataWidth-1:0] writeData;
    } regBus_t;

    // One serial stream, data valid while clkEn is high
    typedef struct packed {
        logic clkEn;
        logic data;
    } bitStream_t;

    // Address spaces in the upper address nibble
    localparam logic [3:0] SpaceBoard    = 4'h0;
    localparam logic [3:0] SpacePn       = 4'h1;
    localparam logic [3:0] SpaceBert     = 4'h2;

    // Board register offsets
    localparam logic [3:0] RegVersion    = 4'h0;
    localparam logic [3:0] RegControl    = 4'h1;
    localparam logic [3:0] RegBertSelect = 4'h2;
    localparam logic [3:0] RegOutSelect  = 4'h3;

    // PN generator and BERT offsets
    localparam logic [3:0] RegPnRate     = 4'h0;
    localparam logic [3:0] RegBitCount   = 4'h0;
    localparam logic [3:0] RegErrorCount = 4'h1;

    // PN15 pattern, x^15 + x^14 + 1
    localparam int                  PnLength = 15;
    localparam logic [PnLength-1:0] PnSeed   = '1;

    // Stream multiplexer sources
    localparam int NumStreams  = 8;
    localparam int SrcPn       = 0;
    localparam int SrcSerialIn = 1;

endpackage
